// File: build.f
+incdir+source
source/refill_pkg.sv
source/refill_data_upsize.sv
source/refill_ctrl.sv
source/line_data_array.sv
source/refill_top.sv
verification/refill_tb.sv

// File: Makefile
# Verilator flow for the refill data path

VERILATOR  := verilator
TOP        := refill_tb
RTL_TOP    := refill_top
FILELIST   := build.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_TEXT  := === PASS ===
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/refill_tb.sv
// ##########################################################
// Testbench for the refill data path top level
// Memory model answers requests in order with LFSR beats
// Short lines and gaps on mem_rvalid_i are random
// Stops at the first mismatch or timeout
// ##########################################################

`default_nettype none

`include "refill_defs.svh"

module refill_tb;

    localparam int WORDS      = `REFILL_LINE_WIDTH / `REFILL_BEAT_WIDTH;
    localparam int WAIT_LIMIT = 200;

    logic              clk_i;
    logic              rst_ni;
    logic              miss_i;
    refill_pkg::set_t  miss_set_i;
    logic              miss_full_o;
    logic              mem_req_o;
    refill_pkg::set_t  mem_set_o;
    logic              mem_rvalid_i;
    logic              mem_rlast_i;
    refill_pkg::beat_t mem_rdata_i;
    logic              mem_rready_o;
    logic              fill_done_o;
    refill_pkg::set_t  fill_set_o;
    logic              rd_i;
    refill_pkg::set_t  rd_set_i;
    refill_pkg::line_t rd_data_o;

    // Scoreboard state
    refill_pkg::set_t  exp_set_q[$];
    refill_pkg::line_t exp_line_q[$];
    int                take_q[$];
    refill_pkg::set_t  req_q[$];
    refill_pkg::line_t model_mem [`REFILL_SETS];
    logic [31:0]       lfsr_state = 32'haa88;
    int                cycle = 0;
    string             test_name = "reset";
    // Memory model knobs
    // A zero length picks a random line length
    int                force_len = 4;
    logic              gaps_en = 1'b0;

    refill_top refill_top_inst (.*);

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle <= cycle + 1;

    // Galois LFSR stepped once per returned bit
    function automatic logic [31:0] lfsr_bits(input int count);
        logic [31:0] value;
        logic        out_bit;
        value = '0;
        for (int i = 0; i < count; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) begin
                lfsr_state = lfsr_state ^ 32'h80200003;
            end
            value = {value[30:0], out_bit};
        end
        return value;
    endfunction

    // Beats in order from word 0 with unsent words left zero
    function automatic refill_pkg::line_t expected_line(input refill_pkg::beat_t beats [WORDS],
                                                         input int sent);
        refill_pkg::line_t line;
        line = '0;
        for (int i = 0; i < WORDS; i++) begin
            if (i < sent) begin
                line[i] = beats[i];
            end
        end
        return line;
    endfunction

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "stopped in test %s", test_name);
    endtask

    task automatic check_value(input string what, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (exp === act) else begin
            $display("FAIL %s %s: expected %0h actual %0h", test_name, what, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    // Called and returns in the drive slot
    task automatic do_miss(input refill_pkg::set_t s);
        int waited;
        waited = 0;
        while (miss_full_o) begin
            @(posedge clk_i);
            #1;
            waited++;
            assert (waited < WAIT_LIMIT) else stop_with_error("miss queue never drained");
        end
        miss_i     = 1'b1;
        miss_set_i = s;
        exp_set_q.push_back(s);
        @(posedge clk_i);
        #1;
        miss_i = 1'b0;
        // Request one cycle after the accepted miss
        check_value("mem_req_o", 128'(1), 128'(mem_req_o));
        check_value("mem_set_o", 128'(s), 128'(mem_set_o));
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_set_q.size() != 0) begin
            @(posedge clk_i);
            #1;
            waited++;
            assert (waited < WAIT_LIMIT * 8) else stop_with_error("refills never completed");
        end
    endtask

    task automatic read_check(input refill_pkg::set_t s);
        rd_i     = 1'b1;
        rd_set_i = s;
        @(posedge clk_i);
        #1;
        rd_i = 1'b0;
        check_value($sformatf("set %0d", s), model_mem[s], rd_data_o);
    endtask

    // Sends one line beat by beat and holds each until taken
    task automatic serve_refill();
        refill_pkg::beat_t beats [WORDS];
        int                sent;
        int                tries;
        int                gap;
        int                take_cycle;
        logic              taken;
        sent = force_len;
        if (sent == 0) begin
            sent = (lfsr_bits(2) == 0) ? 1 + int'(lfsr_bits(2) % 3) : WORDS;
        end
        beats      = '{default: '0};
        take_cycle = 0;
        for (int i = 0; i < sent; i++) begin
            gap = 0;
            while (gaps_en && gap < 3 && lfsr_bits(2) == 0) begin
                mem_rvalid_i = 1'b0;
                @(posedge clk_i);
                #1;
                gap++;
            end
            beats[i]     = lfsr_bits(32);
            mem_rvalid_i = 1'b1;
            mem_rdata_i  = beats[i];
            // Early end only marks short lines
            mem_rlast_i  = (i == sent - 1) && (sent < WORDS);
            tries        = 0;
            taken        = 1'b0;
            while (!taken) begin
                @(negedge clk_i);
                taken = mem_rready_o;
                @(posedge clk_i);
                #1;
                take_cycle = cycle;
                tries++;
                assert (tries < WAIT_LIMIT) else stop_with_error("memory beat never accepted");
            end
        end
        mem_rvalid_i = 1'b0;
        mem_rlast_i  = 1'b0;
        exp_line_q.push_back(expected_line(beats, sent));
        take_q.push_back(take_cycle);
    endtask

    initial begin : memory_model
        mem_rvalid_i = 1'b0;
        mem_rlast_i  = 1'b0;
        mem_rdata_i  = '0;
        forever begin
            @(posedge clk_i);
            if (req_q.size() != 0) begin
                #1;
                void'(req_q.pop_front());
                serve_refill();
            end
        end
    end

    initial begin : request_monitor
        forever begin
            @(negedge clk_i);
            if (rst_ni && mem_req_o) begin
                req_q.push_back(mem_set_o);
            end
        end
    end

    initial begin : compare_fills
        refill_pkg::set_t  set_exp;
        refill_pkg::line_t line_exp;
        int                take_cycle;
        model_mem = '{default: '0};
        forever begin
            @(negedge clk_i);
            if (rst_ni && fill_done_o) begin
                assert (exp_set_q.size() != 0 && exp_line_q.size() != 0)
                    else stop_with_error("fill_done_o pulsed with no refill outstanding");
                set_exp    = exp_set_q.pop_front();
                line_exp   = exp_line_q.pop_front();
                take_cycle = take_q.pop_front();
                check_value("fill_set_o", 128'(set_exp), 128'(fill_set_o));
                // Last beat at edge N gives fill_done_o after edge N+1
                check_value("fill timing", 128'(take_cycle + 1), 128'(cycle));
                model_mem[set_exp] = line_exp;
            end
        end
    end

    initial begin : main_sequence
        int               waited;
        refill_pkg::set_t set_a;
        refill_pkg::set_t set_b;
        rst_ni     = 1'b0;
        miss_i     = 1'b0;
        miss_set_i = '0;
        rd_i       = 1'b0;
        rd_set_i   = '0;
        repeat (10) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        test_name = "reset";
        check_value("mem_req_o", 128'(0), 128'(mem_req_o));
        check_value("fill_done_o", 128'(0), 128'(fill_done_o));
        check_value("miss_full_o", 128'(0), 128'(miss_full_o));
        check_value("mem_rready_o", 128'(1), 128'(mem_rready_o));
        for (int s = 0; s < `REFILL_SETS; s++) begin
            read_check(refill_pkg::set_t'(s));
        end

        // Two full lines so both buffer entries hold data
        test_name = "full";
        do_miss(4'd3);
        wait_idle();
        read_check(4'd3);
        do_miss(4'd4);
        wait_idle();
        read_check(4'd4);

        test_name = "short";
        for (int len = 1; len < WORDS; len++) begin
            force_len = len;
            do_miss(refill_pkg::set_t'(10 + len));
            wait_idle();
            read_check(refill_pkg::set_t'(10 + len));
        end

        test_name = "two outstanding";
        force_len = WORDS;
        do_miss(4'd8);
        do_miss(4'd9);
        check_value("miss_full_o", 128'(1), 128'(miss_full_o));
        waited = 0;
        while (miss_full_o) begin
            @(posedge clk_i);
            #1;
            waited++;
            assert (waited < WAIT_LIMIT) else stop_with_error("miss_full_o never fell");
        end
        // Queue frees at the same edge as the first fill
        check_value("fill_done_o", 128'(1), 128'(fill_done_o));
        check_value("fill_set_o", 128'(8), 128'(fill_set_o));
        wait_idle();
        read_check(4'd8);
        read_check(4'd9);

        test_name = "random gaps";
        force_len = 0;
        gaps_en   = 1'b1;
        repeat (20) begin
            // Sets drawn while memory is idle
            // Distinct sets keep both lines readable
            set_a = refill_pkg::set_t'(lfsr_bits(4));
            set_b = refill_pkg::set_t'(set_a + 1 + lfsr_bits(3));
            do_miss(set_a);
            do_miss(set_b);
            wait_idle();
            read_check(set_a);
            read_check(set_b);
        end
        for (int s = 0; s < `REFILL_SETS; s++) begin
            read_check(refill_pkg::set_t'(s));
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/refill_top.sv
// ##########################################################
// Refill data path top level
// Memory must hold a beat and its valid until mem_rready_o
// miss_i may only pulse while miss_full_o is low
// ##########################################################

`default_nettype none

module refill_top (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,

    // Miss side
    input  wire logic              miss_i,
    input  wire refill_pkg::set_t  miss_set_i,
    output logic                   miss_full_o,

    // Memory request
    output logic                   mem_req_o,
    output refill_pkg::set_t       mem_set_o,

    // Memory response
    input  wire logic              mem_rvalid_i,
    input  wire logic              mem_rlast_i,
    input  wire refill_pkg::beat_t mem_rdata_i,
    output logic                   mem_rready_o,

    // Fill notification
    output logic                   fill_done_o,
    output refill_pkg::set_t       fill_set_o,

    // Read port
    input  wire logic              rd_i,
    input  wire refill_pkg::set_t  rd_set_i,
    output refill_pkg::line_t      rd_data_o
);

    logic              line_ready;
    logic              pop;
    logic              arr_wr;
    refill_pkg::set_t  arr_wr_set;
    refill_pkg::line_t line_data;

    refill_ctrl refill_ctrl_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .miss_i       (miss_i),
        .miss_set_i   (miss_set_i),
        .miss_full_o  (miss_full_o),
        .mem_req_o    (mem_req_o),
        .mem_set_o    (mem_set_o),
        .line_ready_i (line_ready),
        .pop_o        (pop),
        .wr_o         (arr_wr),
        .wr_set_o     (arr_wr_set),
        .fill_done_o  (fill_done_o),
        .fill_set_o   (fill_set_o)
    );

    // Response valid drives the beat write directly
    refill_data_upsize refill_data_upsize_inst (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .w_i     (mem_rvalid_i),
        .wlast_i (mem_rlast_i),
        .wdata_i (mem_rdata_i),
        .wok_o   (mem_rready_o),
        .r_i     (pop),
        .rok_o   (line_ready),
        .rdata_o (line_data)
    );

    line_data_array line_data_array_inst (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .wr_i      (arr_wr),
        .wr_set_i  (arr_wr_set),
        .wr_data_i (line_data),
        .rd_i      (rd_i),
        .rd_set_i  (rd_set_i),
        .rd_data_o (rd_data_o)
    );

endmodule

`default_nettype wire

// File: source/line_data_array.sv
// ##########################################################
// Line data storage indexed by set
// One write port, one registered read port
// Read and write of one set in one cycle returns old data
// ##########################################################

`default_nettype none

`include "refill_defs.svh"

module line_data_array (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,

    // Write port
    input  wire logic              wr_i,
    input  wire refill_pkg::set_t  wr_set_i,
    input  wire refill_pkg::line_t wr_data_i,

    // Read port
    input  wire logic              rd_i,
    input  wire refill_pkg::set_t  rd_set_i,
    output refill_pkg::line_t      rd_data_o
);

    localparam int SETS = `REFILL_SETS;

    refill_pkg::line_t mem_q [SETS];

    // Storage cleared on reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < SETS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr_i) begin
            mem_q[wr_set_i] <= wr_data_i;
        end
    end

    // Read data holds between reads
    always_ff @(posedge clk_i) begin
        if (rd_i) begin
            rd_data_o <= mem_q[rd_set_i];
        end
    end

endmodule

`default_nettype wire

// File: source/refill_ctrl.sv
// ##########################################################
// Refill controller issuing one memory request per miss
// Refills complete strictly in request order
// Miss pulses are only legal while miss_full_o is low
// ##########################################################

`default_nettype none

`include "refill_defs.svh"

module refill_ctrl (
    input  wire logic             clk_i,
    input  wire logic             rst_ni,

    // Miss side
    input  wire logic             miss_i,
    input  wire refill_pkg::set_t miss_set_i,
    output logic                  miss_full_o,

    // Memory request
    output logic                  mem_req_o,
    output refill_pkg::set_t      mem_set_o,

    // Upsize buffer
    input  wire logic             line_ready_i,
    output logic                  pop_o,

    // Array write
    output logic                  wr_o,
    output refill_pkg::set_t      wr_set_o,

    // Fill notification
    output logic                  fill_done_o,
    output refill_pkg::set_t      fill_set_o
);

    localparam int DEPTH = `REFILL_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    // Pending sets with the oldest at rd_ptr_q
    refill_pkg::set_t set_q [DEPTH];

    ptr_t wr_ptr_q;
    ptr_t rd_ptr_q;
    cnt_t count_q;

    function automatic ptr_t next_ptr(input ptr_t p);
        return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign miss_full_o = (count_q == cnt_t'(DEPTH));

    // Finished line goes to the array in the same cycle
    assign pop_o    = line_ready_i;
    assign wr_o     = line_ready_i;
    assign wr_set_o = set_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            mem_req_o   <= 1'b0;
            fill_done_o <= 1'b0;
        end else begin
            if (miss_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (line_ready_i) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({miss_i, line_ready_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            mem_req_o   <= miss_i;
            fill_done_o <= line_ready_i;
        end
    end

    // Set payload captured on the miss and line strobes
    always_ff @(posedge clk_i) begin
        if (miss_i) begin
            set_q[wr_ptr_q] <= miss_set_i;
            mem_set_o       <= miss_set_i;
        end
        if (line_ready_i) begin
            fill_set_o <= set_q[rd_ptr_q];
        end
    end

    a_no_miss_full : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        miss_i |-> !miss_full_o
    ) else $error("miss accepted while refill queue full");

    // Every line from memory belongs to a queued refill
    a_line_has_set : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        line_ready_i |-> (count_q != '0)
    ) else $error("line ready with no refill outstanding");

endmodule

`default_nettype wire

// File: source/refill_data_upsize.sv
// ##########################################################
// Packs narrow memory beats into whole cache lines
// wlast_i closes a line early, missing words read as zero
// A beat offered while full must be held by the sender
// Depth must be at least 2
// ##########################################################

`default_nettype none

`include "refill_defs.svh"

module refill_data_upsize (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,

    // Beat write side
    input  wire logic              w_i,
    input  wire logic              wlast_i,
    input  wire refill_pkg::beat_t wdata_i,
    output logic                   wok_o,

    // Line read side
    input  wire logic              r_i,
    output logic                   rok_o,
    output refill_pkg::line_t      rdata_o
);

    localparam int DEPTH = `REFILL_DEPTH;
    localparam int WORDS = `REFILL_LINE_WIDTH / `REFILL_BEAT_WIDTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] used_t;

    // Line entries and their beat counters
    refill_pkg::line_t     buf_q [DEPTH];
    refill_pkg::word_cnt_t cnt_q [DEPTH];

    ptr_t  wr_ptr_q;
    ptr_t  rd_ptr_q;
    used_t used_q;

    logic push_beat;
    logic close_line;
    logic pop_line;

    // Circular pointer step
    function automatic ptr_t next_ptr(input ptr_t p);
        return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Full counts closed lines only
    assign wok_o = (used_q != used_t'(DEPTH));
    assign rok_o = (used_q != '0);

    assign push_beat  = w_i && wok_o;
    // Last slot reached or early end from memory
    assign close_line = push_beat &&
                        (wlast_i || cnt_q[wr_ptr_q] == refill_pkg::word_cnt_t'(WORDS - 1));
    assign pop_line   = r_i && rok_o;

    // Oldest closed line
    assign rdata_o = buf_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            used_q   <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            if (close_line) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop_line) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end

            case ({close_line, pop_line})
                2'b10:   used_q <= used_q + 1'b1;
                2'b01:   used_q <= used_q - 1'b1;
                default: used_q <= used_q;
            endcase

            // Counter holds its value once the line is closed
            if (push_beat && !close_line) begin
                cnt_q[wr_ptr_q] <= cnt_q[wr_ptr_q] + 1'b1;
            end
            // Write and read entries never coincide here
            if (pop_line) begin
                cnt_q[rd_ptr_q] <= '0;
            end
        end
    end

    // Entries start at zero and go back to zero on pop
    // so words never received read as zero
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < DEPTH; i++) begin
                buf_q[i] <= '0;
            end
        end else begin
            if (pop_line) begin
                buf_q[rd_ptr_q] <= '0;
            end
            if (push_beat) begin
                buf_q[wr_ptr_q][cnt_q[wr_ptr_q]] <= wdata_i;
            end
        end
    end

    // Beat refused while full stays on the bus unchanged
    a_hold_when_full : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (w_i && !wok_o) |=> (w_i && $stable(wdata_i) && $stable(wlast_i))
    ) else $error("beat dropped while upsize buffer full");

    // Reader only pops closed lines
    a_no_pop_empty : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        r_i |-> rok_o
    ) else $error("pop from empty upsize buffer");

endmodule

`default_nettype wire

// File: source/refill_pkg.sv
// ##########################################################
// Data types shared by the refill data path
// All widths come from the macros in refill_defs.svh
// A line is packed as beats, beat 0 in the low bits
// ##########################################################

`default_nettype none

`include "refill_defs.svh"

package refill_pkg;

    // One memory beat
    typedef logic [`REFILL_BEAT_WIDTH-1:0] beat_t;

    // Whole cache line built from beats
    // Index 0 is the first beat returned by memory
    typedef beat_t [`REFILL_LINE_WIDTH/`REFILL_BEAT_WIDTH-1:0] line_t;

    // Set index
    typedef logic [`REFILL_SET_WIDTH-1:0] set_t;

    // Beat position within a line
    typedef logic [$clog2(`REFILL_LINE_WIDTH/`REFILL_BEAT_WIDTH)-1:0] word_cnt_t;

endpackage

`default_nettype wire

// File: source/refill_defs.svh
// ##########################################################
// Widths and sizes of the cache refill data path
// Line width must be a whole multiple of the beat width
// REFILL_DEPTH must be at least 2
// REFILL_SET_WIDTH must cover REFILL_SETS
// ##########################################################

`ifndef REFILL_DEFS_SVH
`define REFILL_DEFS_SVH

// Width of one memory response beat
`define REFILL_BEAT_WIDTH 32

// Width of one cache line
`define REFILL_LINE_WIDTH 128

// Line entries in the upsize buffer
// Also the limit on outstanding refills
`define REFILL_DEPTH 2

// Sets in the line data array
`define REFILL_SETS 16

// Set index width
`define REFILL_SET_WIDTH 4

`endif
